//--- common/ppu_types_pkg.sv
package ppu_types_pkg;

  // Register file seen by the background path
  // LY and the scroll registers are expected to hold still for a whole line
  typedef struct packed {
    logic [7:0] lcdc;
    logic [7:0] scy;
    logic [7:0] scx;
    logic [7:0] ly;
  } ppu_regs_t;

  // PPU mode as reported on the STAT mode field
  // Mode 1 (vblank) is never produced by a single scanline renderer
  typedef enum logic [1:0] {
    mode_hblank = 2'd0,
    mode_oam    = 2'd2,
    mode_draw   = 2'd3
  } ppu_mode_t;

  // One output pixel with its screen column
  // Color is the raw 2-bit shade index before any palette lookup
  typedef struct packed {
    logic [1:0] color;
    logic [7:0] x;
  } pixel_t;

  // One row of a tile as two bitplanes
  // Bit 7 of each plane belongs to the leftmost pixel
  typedef struct packed {
    logic [7:0] low;
    logic [7:0] high;
  } tile_row_t;

  // Byte address inside the 8 KB video RAM
  typedef logic [12:0] vram_addr_t;

  // LCDC bit that picks the background tile map (0x1C00 when set)
  localparam int lcdc_bg_map_bit = 3;

  // LCDC bit that picks unsigned tile data at 0x0000 when set
  // When clear the tile index is signed and based at 0x1000
  localparam int lcdc_tile_data_bit = 4;

endpackage

//--- common/ppu_timing_pkg.sv
package ppu_timing_pkg;

  // Length of the OAM search window at the start of every line
  localparam int oam_dots = 80;

  // Total dots in one scanline, mode 2 plus mode 3 plus mode 0
  localparam int line_dots = 456;

  // Visible pixels per line and pixels per tile row
  localparam int screen_width = 160;
  localparam int tile_width   = 8;

  // Tile map bases, each map is 32 by 32 one-byte entries
  localparam ppu_types_pkg::vram_addr_t map_base_low  = 13'h1800;
  localparam ppu_types_pkg::vram_addr_t map_base_high = 13'h1C00;

  // Tile data bases for the two addressing modes
  localparam ppu_types_pkg::vram_addr_t tile_base_unsigned = 13'h0000;
  localparam ppu_types_pkg::vram_addr_t tile_base_signed   = 13'h1000;

endpackage

//--- source/dot_timer.sv
`timescale 1ns/100ps

module dot_timer (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     line_start,
  input  logic                     draw_done,
  output ppu_types_pkg::ppu_mode_t mode,
  output logic                     draw_start,
  output logic                     line_done
);

  // Dot position inside the current line, 0 to 455
  logic [8:0] dot;

  // High from the dot after line_start until line_done
  logic       active;

  // Set once the pixel buffer reports the last pixel of the line
  logic       draw_over;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      dot       <= '0;
      active    <= 1'b0;
      draw_over <= 1'b0;
    end else if (line_start) begin
      // Dot 0 is the first cycle after the pulse
      dot       <= '0;
      active    <= 1'b1;
      draw_over <= 1'b0;
    end else if (active) begin
      // The counter parks on the last dot and the timer goes idle
      if (line_done) begin
        active <= 1'b0;
      end else begin
        dot <= dot + 9'd1;
      end
      if (draw_done) begin
        draw_over <= 1'b1;
      end
    end
  end

  // Mode decode from the counter and the draw flag
  // Mode 3 length depends on fetch latency, so its end comes from draw_over
  always_comb begin
    if (!active) begin
      mode = ppu_types_pkg::mode_hblank;
    end else if (dot < 9'(ppu_timing_pkg::oam_dots)) begin
      mode = ppu_types_pkg::mode_oam;
    end else if (draw_over) begin
      mode = ppu_types_pkg::mode_hblank;
    end else begin
      mode = ppu_types_pkg::mode_draw;
    end
  end

  // First dot of mode 3
  assign draw_start = active && (dot == 9'(ppu_timing_pkg::oam_dots));

  // Last dot of the line
  assign line_done = active && (dot == 9'(ppu_timing_pkg::line_dots - 1));

endmodule

//--- fetcher/tile_addr_gen.sv
`timescale 1ns/100ps

module tile_addr_gen (
  input  ppu_types_pkg::ppu_regs_t  regs,
  input  logic [4:0]                tile_col,
  input  logic [7:0]                tile_index,
  input  logic                      row_sel_high,
  output ppu_types_pkg::vram_addr_t map_addr,
  output ppu_types_pkg::vram_addr_t row_addr
);

  // Background line being drawn, wraps at 256
  logic [7:0]                bg_y;

  // Map base picked by LCDC bit 3
  ppu_types_pkg::vram_addr_t map_base;

  // Tile data base picked by LCDC bit 4
  ppu_types_pkg::vram_addr_t tile_base;

  // Index times 16, sign extended in signed mode
  ppu_types_pkg::vram_addr_t tile_offset;

  // Fine row times 2, plus one for the high bitplane
  ppu_types_pkg::vram_addr_t row_offset;

  logic                      unsigned_mode;

  assign bg_y          = regs.scy + regs.ly;
  assign unsigned_mode = regs.lcdc[ppu_types_pkg::lcdc_tile_data_bit];

  assign map_base = regs.lcdc[ppu_types_pkg::lcdc_bg_map_bit] ?
                    ppu_timing_pkg::map_base_high : ppu_timing_pkg::map_base_low;

  // Coarse row times 32 plus the column is a 10-bit map offset
  assign map_addr = map_base + {3'b000, bg_y[7:3], tile_col};

  assign tile_base = unsigned_mode ?
                     ppu_timing_pkg::tile_base_unsigned : ppu_timing_pkg::tile_base_signed;

  // In signed mode index 0x80 reaches back to 0x0800, the shared block
  assign tile_offset = unsigned_mode ? {1'b0, tile_index, 4'b0000} :
                                       {tile_index[7], tile_index, 4'b0000};

  assign row_offset = {9'd0, bg_y[2:0], row_sel_high};

  // Sum wraps at 8 KB, which keeps signed mode inside VRAM
  assign row_addr = tile_base + tile_offset + row_offset;

endmodule

//--- fetcher/bg_fetcher.sv
`timescale 1ns/100ps

module bg_fetcher (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      line_start,
  input  logic                      draw_start,
  input  ppu_types_pkg::ppu_mode_t  mode,
  input  ppu_types_pkg::ppu_regs_t  regs,
  input  ppu_types_pkg::vram_addr_t map_addr,
  input  ppu_types_pkg::vram_addr_t row_addr,
  output logic [4:0]                tile_col,
  output logic [7:0]                tile_index,
  output logic                      row_sel_high,
  output logic                      vram_req,
  output ppu_types_pkg::vram_addr_t vram_addr,
  input  logic                      vram_ack,
  input  logic [7:0]                vram_rdata,
  output ppu_types_pkg::tile_row_t  row,
  output logic                      row_push,
  input  logic                      row_empty
);

  typedef enum logic [1:0] {
    get_tile,
    get_low,
    get_high,
    push
  } fetch_state_t;

  // Request phase waits for ack high, release phase waits for ack low
  typedef enum logic {
    phase_request,
    phase_release
  } phase_t;

  fetch_state_t              state;
  phase_t                    phase;

  // New reads only start while drawing
  logic                      fetch_enable;

  // Ack seen on an open request, data is valid this cycle
  logic                      read_accept;

  // Address for the read that the current state wants
  ppu_types_pkg::vram_addr_t fetch_addr;

  function automatic fetch_state_t next_fetch_state(input fetch_state_t cur);
    case (cur)
      get_tile: next_fetch_state = get_low;
      get_low:  next_fetch_state = get_high;
      default:  next_fetch_state = push;
    endcase
  endfunction

  assign fetch_enable = (mode == ppu_types_pkg::mode_draw);
  assign read_accept  = vram_req && vram_ack;
  assign row_sel_high = (state == get_high);
  assign fetch_addr   = (state == get_tile) ? map_addr : row_addr;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state     <= get_tile;
      phase     <= phase_request;
      tile_col  <= '0;
      vram_req  <= 1'b0;
      vram_addr <= '0;
      row_push  <= 1'b0;
    end else if (line_start) begin
      state    <= get_tile;
      phase    <= phase_request;
      tile_col <= '0;
      vram_req <= 1'b0;
      row_push <= 1'b0;
    end else if (draw_start) begin
      // The first tile is the one holding background x = SCX
      // No read starts here since the map address still has the old column
      tile_col <= regs.scx[7:3];
      row_push <= 1'b0;
    end else begin
      row_push <= 1'b0;
      if (state == push) begin
        // Wait here until the buffer has drained its current row
        if (fetch_enable && row_empty) begin
          row_push <= 1'b1;
          tile_col <= tile_col + 5'd1;
          state    <= get_tile;
        end
      end else if (phase == phase_request) begin
        if (read_accept) begin
          vram_req <= 1'b0;
          phase    <= phase_release;
        end else if (!vram_req && !vram_ack && fetch_enable) begin
          // Address is captured once and held for the whole request
          vram_req  <= 1'b1;
          vram_addr <= fetch_addr;
        end
      end else if (!vram_ack) begin
        // Handshake closed, this also runs after mode 3 so no read is left open
        phase <= phase_request;
        state <= next_fetch_state(state);
      end
    end
  end

  // Read data lands in the register for the current state
  always_ff @(posedge clk) begin
    if (read_accept) begin
      case (state)
        get_tile: tile_index <= vram_rdata;
        get_low:  row.low    <= vram_rdata;
        get_high: row.high   <= vram_rdata;
        default:  ;
      endcase
    end
  end

endmodule

//--- source/bg_pixel_buffer.sv
`timescale 1ns/100ps

module bg_pixel_buffer (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     line_start,
  input  logic                     draw_start,
  input  ppu_types_pkg::ppu_mode_t mode,
  input  ppu_types_pkg::ppu_regs_t regs,
  input  ppu_types_pkg::tile_row_t row,
  input  logic                     row_push,
  output logic                     row_empty,
  output ppu_types_pkg::pixel_t    pixel,
  output logic                     pixel_valid,
  output logic                     draw_done
);

  // Bitplane shift registers, leftmost pixel sits in bit 7
  logic [7:0] shift_low;
  logic [7:0] shift_high;

  // Pixels still held from the current row, 0 to 8
  logic [3:0] pixels_left;

  // Fine-scroll pixels still to drop at the start of the line
  logic [2:0] discard;

  // Screen column of the next visible pixel
  logic [7:0] x_count;

  // High from draw_start until the last pixel has gone out
  logic       emitting;

  logic       load;
  logic       shift_en;
  logic       last_pixel;

  assign row_empty  = (pixels_left == 4'd0);
  assign load       = row_push && row_empty;
  assign shift_en   = emitting && !row_empty && (mode == ppu_types_pkg::mode_draw);
  assign last_pixel = (x_count == 8'(ppu_timing_pkg::screen_width - 1));

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pixels_left <= '0;
      discard     <= '0;
      x_count     <= '0;
      emitting    <= 1'b0;
      pixel_valid <= 1'b0;
      draw_done   <= 1'b0;
    end else if (line_start) begin
      pixels_left <= '0;
      discard     <= '0;
      x_count     <= '0;
      emitting    <= 1'b0;
      pixel_valid <= 1'b0;
      draw_done   <= 1'b0;
    end else begin
      pixel_valid <= 1'b0;
      draw_done   <= 1'b0;
      if (draw_start) begin
        discard  <= regs.scx[2:0];
        x_count  <= '0;
        emitting <= 1'b1;
      end
      if (load) begin
        pixels_left <= 4'(ppu_timing_pkg::tile_width);
      end else if (shift_en) begin
        pixels_left <= pixels_left - 4'd1;
        if (discard != 3'd0) begin
          // Dropped pixel shifts out silently
          discard <= discard - 3'd1;
        end else begin
          pixel_valid <= 1'b1;
          x_count     <= x_count + 8'd1;
          // The 160th pixel ends mode 3, leftover bits are never shown
          if (last_pixel) begin
            draw_done <= 1'b1;
            emitting  <= 1'b0;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      shift_low  <= row.low;
      shift_high <= row.high;
    end else if (shift_en) begin
      shift_low  <= {shift_low[6:0], 1'b0};
      shift_high <= {shift_high[6:0], 1'b0};
    end
    // Output word follows the shifter, pixel_valid tells which ones count
    if (shift_en) begin
      pixel.color <= {shift_high[7], shift_low[7]};
      pixel.x     <= x_count;
    end
  end

endmodule

//--- source/ppu_bg_top.sv
`timescale 1ns/100ps

module ppu_bg_top (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      line_start,
  input  ppu_types_pkg::ppu_regs_t  regs,
  input  logic [7:0]                vram_rdata,
  input  logic                      vram_ack,
  output logic                      vram_req,
  output ppu_types_pkg::vram_addr_t vram_addr,
  output ppu_types_pkg::ppu_mode_t  mode,
  output ppu_types_pkg::pixel_t     pixel,
  output logic                      pixel_valid,
  output logic                      line_done
);

  // Mode 3 start and end pulses between timer and buffer
  logic                      draw_start;
  logic                      draw_done;

  // Address generator inputs and results
  logic [4:0]                tile_col;
  logic [7:0]                tile_index;
  logic                      row_sel_high;
  ppu_types_pkg::vram_addr_t map_addr;
  ppu_types_pkg::vram_addr_t row_addr;

  // Row hand-off from fetcher to buffer
  ppu_types_pkg::tile_row_t  row;
  logic                      row_push;
  logic                      row_empty;

  dot_timer u_dot_timer (
    .clk        (clk),
    .reset      (reset),
    .line_start (line_start),
    .draw_done  (draw_done),
    .mode       (mode),
    .draw_start (draw_start),
    .line_done  (line_done)
  );

  bg_fetcher u_bg_fetcher (
    .clk          (clk),
    .reset        (reset),
    .line_start   (line_start),
    .draw_start   (draw_start),
    .mode         (mode),
    .regs         (regs),
    .map_addr     (map_addr),
    .row_addr     (row_addr),
    .tile_col     (tile_col),
    .tile_index   (tile_index),
    .row_sel_high (row_sel_high),
    .vram_req     (vram_req),
    .vram_addr    (vram_addr),
    .vram_ack     (vram_ack),
    .vram_rdata   (vram_rdata),
    .row          (row),
    .row_push     (row_push),
    .row_empty    (row_empty)
  );

  tile_addr_gen u_tile_addr_gen (
    .regs         (regs),
    .tile_col     (tile_col),
    .tile_index   (tile_index),
    .row_sel_high (row_sel_high),
    .map_addr     (map_addr),
    .row_addr     (row_addr)
  );

  bg_pixel_buffer u_bg_pixel_buffer (
    .clk         (clk),
    .reset       (reset),
    .line_start  (line_start),
    .draw_start  (draw_start),
    .mode        (mode),
    .regs        (regs),
    .row         (row),
    .row_push    (row_push),
    .row_empty   (row_empty),
    .pixel       (pixel),
    .pixel_valid (pixel_valid),
    .draw_done   (draw_done)
  );

endmodule

//--- testbench/vram_model.sv
`timescale 1ns/100ps

module vram_model #(
  // Extra ack delay allowed per scanline, in cycles
  // Mode 3 must fit its 160 pixels before dot 455, and the fetcher is the slow side,
  // so the random delays draw from a per-line pool instead of being unlimited
  parameter int line_credit = 20
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      line_start,
  input  logic                      req,
  input  ppu_types_pkg::vram_addr_t addr,
  output logic                      ack,
  output logic [7:0]                rdata
);

  // 8 KB of video RAM, also read by the reference model in the testbench
  logic [7:0] mem [0:8191];

  // Random state shared by the fill and the ack delays
  int         seed;

  // Delay cycles still available in the current line
  int         credit;

  // Cycles left before ack rises on the open request
  int         delay_left;
  int         delay_pick;

  // A request has been seen and its ack is being delayed
  logic       busy;

  initial begin
    seed = 90676;
    for (int a = 0; a < 8192; a++) begin
      mem[a] = 8'($random(seed));
    end
  end

  always @(posedge clk or posedge reset) begin
    if (reset) begin
      ack        <= 1'b0;
      rdata      <= 8'h00;
      busy       <= 1'b0;
      delay_left <= 0;
      credit     <= line_credit;
    end else begin
      // A new line refills the delay pool
      if (line_start) begin
        credit <= line_credit;
      end
      if (ack) begin
        // Ack stays up until the fetcher has dropped its request
        if (!req) begin
          ack <= 1'b0;
        end
      end else if (busy) begin
        if (delay_left == 0) begin
          ack   <= 1'b1;
          rdata <= mem[addr];
          busy  <= 1'b0;
        end else begin
          delay_left <= delay_left - 1;
        end
      end else if (req) begin
        // Pick 0 to 5 cycles, clipped to what is left of the pool
        delay_pick = {$random(seed)} % 6;
        if (delay_pick > credit) begin
          delay_pick = credit;
        end
        credit <= credit - delay_pick;
        if (delay_pick == 0) begin
          ack   <= 1'b1;
          rdata <= mem[addr];
        end else begin
          busy       <= 1'b1;
          delay_left <= delay_pick - 1;
        end
      end
    end
  end

endmodule

//--- testbench/ppu_bg_tb.sv
`timescale 1ns/100ps

module ppu_bg_tb;

  logic                      clk;
  logic                      reset;
  logic                      line_start;
  ppu_types_pkg::ppu_regs_t  regs;
  logic [7:0]                vram_rdata;
  logic                      vram_ack;
  logic                      vram_req;
  ppu_types_pkg::vram_addr_t vram_addr;
  ppu_types_pkg::ppu_mode_t  mode;
  ppu_types_pkg::pixel_t     pixel;
  logic                      pixel_valid;
  logic                      line_done;

  // Name of the running scenario for error lines
  string                     test_name;
  int                        seed;

  // Line monitor state that advances at the falling edge
  logic                      in_line;
  int                        cur_dot;
  int                        pixels_seen;

  // Handshake values from the previous cycle
  logic                      prev_req;
  logic                      prev_ack;
  ppu_types_pkg::vram_addr_t prev_addr;

  ppu_bg_top UUT (
    .clk         (clk),
    .reset       (reset),
    .line_start  (line_start),
    .regs        (regs),
    .vram_rdata  (vram_rdata),
    .vram_ack    (vram_ack),
    .vram_req    (vram_req),
    .vram_addr   (vram_addr),
    .mode        (mode),
    .pixel       (pixel),
    .pixel_valid (pixel_valid),
    .line_done   (line_done)
  );

  vram_model vram (
    .clk        (clk),
    .reset      (reset),
    .line_start (line_start),
    .req        (vram_req),
    .addr       (vram_addr),
    .ack        (vram_ack),
    .rdata      (vram_rdata)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic expect_equal(input string what, input int expected, input int actual);
    assert (expected == actual) else
      stop_with_failure($sformatf("** Error: %s: %s expected %0d, actual %0d",
                                  test_name, what, expected, actual));
  endtask

  // Background color of screen column x worked out from VRAM contents
  function automatic int ref_color(input int x);
    int         bgx;
    int         bgy;
    int         map_entry;
    int         tile_addr;
    int         bit_pos;
    logic [7:0] lo;
    logic [7:0] hi;
    bgx = (regs.scx + x) % 256;
    bgy = (regs.scy + regs.ly) % 256;
    // Map is 32 by 32 entries and LCDC bit 3 picks the upper copy
    map_entry = vram.mem[(regs.lcdc[3] ? 'h1C00 : 'h1800) + (bgy / 8) * 32 + bgx / 8];
    if (regs.lcdc[4]) begin
      tile_addr = map_entry * 16;
    end else begin
      tile_addr = 'h1000 + (map_entry < 128 ? map_entry : map_entry - 256) * 16;
    end
    tile_addr = (tile_addr + (bgy % 8) * 2) % 8192;
    lo = vram.mem[tile_addr];
    hi = vram.mem[tile_addr + 1];
    bit_pos = 7 - bgx % 8;
    ref_color = {hi[bit_pos], lo[bit_pos]};
  endfunction

  // Mode sequence, pixel order, pixel colors and line length
  always @(negedge clk) begin
    if (!reset) begin
      if (in_line) begin
        if (cur_dot < 80) begin
          expect_equal("mode", int'(ppu_types_pkg::mode_oam), int'(mode));
        end else if (pixels_seen < 160) begin
          expect_equal("mode", int'(ppu_types_pkg::mode_draw), int'(mode));
        end else begin
          expect_equal("mode", int'(ppu_types_pkg::mode_hblank), int'(mode));
        end
        if (pixel_valid) begin
          // Every visible pixel belongs to mode 3
          expect_equal("mode at pixel", int'(ppu_types_pkg::mode_draw), int'(mode));
          expect_equal("pixel x", pixels_seen, int'(pixel.x));
          expect_equal("pixel color", ref_color(pixels_seen), int'(pixel.color));
          pixels_seen = pixels_seen + 1;
        end
        expect_equal("line_done", int'(cur_dot == 455), int'(line_done));
        if (cur_dot == 455) begin
          expect_equal("pixels per line", 160, pixels_seen);
          in_line = 1'b0;
        end
        cur_dot = cur_dot + 1;
      end else begin
        // Idle between lines
        expect_equal("idle mode", int'(ppu_types_pkg::mode_hblank), int'(mode));
        expect_equal("idle pixel_valid", 0, int'(pixel_valid));
        expect_equal("idle line_done", 0, int'(line_done));
      end
      // Dot 0 is the cycle after the line_start pulse
      if (line_start) begin
        in_line     = 1'b1;
        cur_dot     = 0;
        pixels_seen = 0;
      end
    end
  end

  // Four-phase handshake rules on the VRAM port
  always @(negedge clk) begin
    if (!reset) begin
      if (vram_req && !prev_req) begin
        assert (!prev_ack && !vram_ack) else
          stop_with_failure("Handshake error: vram_req rose while vram_ack was high");
      end
      if (vram_req && prev_req) begin
        expect_equal("vram_addr during request", int'(prev_addr), int'(vram_addr));
      end
    end
    prev_req  = vram_req;
    prev_ack  = vram_ack;
    prev_addr = vram_addr;
  end

  task automatic wait_line_done();
    int   cycles;
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < 600) begin
      @(negedge clk);
      seen   = line_done;
      cycles = cycles + 1;
    end
    assert (seen) else
      stop_with_failure($sformatf("Timeout in %s: line_done never came", test_name));
  endtask

  task automatic run_line(input string name, input logic [7:0] lcdc, input logic [7:0] scy,
                          input logic [7:0] scx, input logic [7:0] ly);
    test_name = name;
    @(posedge clk);
    regs       <= {lcdc, scy, scx, ly};
    line_start <= 1'b1;
    @(posedge clk);
    line_start <= 1'b0;
    wait_line_done();
    // A short idle gap before the next line
    repeat (6) @(posedge clk);
  endtask

  initial begin
    logic [7:0] r_lcdc;
    logic [7:0] r_scx;
    logic [7:0] r_scy;
    logic [7:0] r_ly;
    seed        = 90676;
    reset       = 1'b1;
    line_start  = 1'b0;
    regs        = '0;
    in_line     = 1'b0;
    cur_dot     = 0;
    pixels_seen = 0;
    prev_req    = 1'b0;
    prev_ack    = 1'b0;
    prev_addr   = '0;
    test_name   = "reset";
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    expect_equal("vram_req after reset", 0, int'(vram_req));
    expect_equal("pixel_valid after reset", 0, int'(pixel_valid));
    expect_equal("line_done after reset", 0, int'(line_done));
    expect_equal("mode after reset", int'(ppu_types_pkg::mode_hblank), int'(mode));

    run_line("no_scroll", 8'h91, 8'h00, 8'h00, 8'h00);
    run_line("fine_scroll_3", 8'h91, 8'h05, 8'h03, 8'h0A);
    run_line("scroll_wrap", 8'h91, 8'hF0, 8'hFF, 8'h14);
    // LCDC bit 4 clear selects signed tile numbers around 0x1000
    run_line("signed_tiles", 8'h81, 8'h07, 8'h2D, 8'h3C);
    // LCDC bit 3 set selects the map at 0x1C00
    run_line("map_high", 8'h99, 8'h00, 8'h55, 8'h64);
    run_line("signed_map_high", 8'h89, 8'h9A, 8'hC6, 8'h77);
    // Random lines over all four addressing combinations
    for (int i = 0; i < 4; i++) begin
      r_lcdc = 8'h81 | (8'(i) << 3);
      r_scx  = 8'($random(seed));
      if (r_scx[2:0] == 3'd0) begin
        r_scx[0] = 1'b1;
      end
      r_scy = 8'($random(seed));
      // LY stays on a visible line
      r_ly  = 8'({$random(seed)} % 144);
      run_line($sformatf("random_line_%0d", i), r_lcdc, r_scy, r_scx, r_ly);
    end

    $display("TESTS PASSED");
    $finish;
  end

endmodule

//--- vlog.f
common/ppu_types_pkg.sv
common/ppu_timing_pkg.sv
source/dot_timer.sv
fetcher/tile_addr_gen.sv
fetcher/bg_fetcher.sv
source/bg_pixel_buffer.sv
source/ppu_bg_top.sv
testbench/vram_model.sv
testbench/ppu_bg_tb.sv
